// File: files.f
src/vid_pkg.sv
src/timing_cfg_if.sv
src/vid_regs.sv
src/pixel_fetch.sv
src/pixel_fifo.sv
src/line_timing.sv
src/vid_ctrl.sv
verif/vid_ctrl_checker.sv
verif/vid_ctrl_tb.sv

// File: Bender.yml
package:
  name: vid_ctrl

sources:
  - files:
      - src/vid_pkg.sv
      - src/timing_cfg_if.sv
      - src/vid_regs.sv
      - src/pixel_fetch.sv
      - src/pixel_fifo.sv
      - src/line_timing.sv
      - src/vid_ctrl.sv
  - target: test
    files:
      - verif/vid_ctrl_checker.sv
      - verif/vid_ctrl_tb.sv

// File: verif/vid_ctrl_tb.sv
`default_nettype none

module vid_ctrl_tb;
    import vid_pkg::*;

    typedef struct {
        addr_data_t offset;
        addr_data_t data;
        pdiv_t      pdiv;
        hpos_t      hend;
        hpos_t      hsize;
        hpos_t      hsync_start;
        hpos_t      hsync_end;
    } cfg_row_t;

    localparam int    LINES = 6;               // Full lines measured after enable
    localparam pdiv_t PDIV  = 6'd2;
    localparam hpos_t HEND  = 13'd20;
    localparam hpos_t HSIZE = 13'd12;
    localparam hpos_t HS_ST = 13'd14;
    localparam hpos_t HS_EN = 13'd17;
    localparam addr_data_t BASE = 32'h0000_1000;
    localparam int    WATCHDOG_TIME = (2 * LINES * HEND * (PDIV + 1) + 400) * 100;

    logic       clk = 1'b0;
    logic       reset_n;
    bus_cmd_t   cmd_in;
    addr_data_t addr_data_in;
    logic [1:0] req_out;
    bus_cmd_t   cmd_out;
    logic [1:0] len_out;
    addr_data_t addr_data_out;
    logic       hsync;
    logic       hblank;
    colour_t    r;
    colour_t    g;
    colour_t    b;

    cfg_row_t   table_rows[5];
    cfg_row_t   exp_cfg;          // Configuration the line timing runs with
    cfg_row_t   wr_q[$];          // Register writes waiting for the bus
    time        resp_q[$];        // Sample times of expected write responses
    pixel_t     exp_pixels[$];    // Pixels delivered by the bus model
    pixel_t     mem[addr_data_t];
    addr_data_t next_read;
    addr_data_t beat_addr;
    int         beats_left;
    logic       wr_phase;
    int         phase;
    int         lines_seen;
    int         pixels_checked;
    longint     now_cyc;
    longint     fall_cyc;
    longint     hs_rise_cyc;
    logic       fall_valid;
    logic       hs_valid;
    logic       prev_hblank;
    logic       prev_hsync;
    pixel_t     beat_pix;

    vid_ctrl #(.FIFO_DEPTH(8)) vid_ctrl_i (.*);

    bind vid_ctrl vid_ctrl_checker checker_i (.*);

    always #50 clk = ~clk;

    task automatic fail_run();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_cmd(string name, bus_cmd_t got, bus_cmd_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_pixel(string name, pixel_t got, pixel_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %06h, expected %06h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(string name, hpos_t got, hpos_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bits(string name, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_address(string name, addr_data_t got, addr_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %08h, expected %08h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_idle_outputs();
        check_bits("req_out", req_out, 2'd0);
        check_cmd("cmd_out", cmd_out, CMD_IDLE);
        check_bits("hsync", {1'b0, hsync}, 2'd0);
        check_bits("hblank", {1'b0, hblank}, 2'd1);
        check_pixel("rgb", {r, g, b}, '0);
    endtask

    // Clocks taken by a run of pixels at the given divider
    function automatic hpos_t period_clocks(hpos_t pixels, pdiv_t pdiv);
        return hpos_t'(pixels * (pdiv + 1));
    endfunction

    function automatic cfg_row_t make_row(addr_data_t offset, addr_data_t data);
        cfg_row_t row;
        row.offset      = offset;
        row.data        = data;
        row.pdiv        = PDIV;
        row.hend        = HEND;
        row.hsize       = HSIZE;
        row.hsync_start = HS_ST;
        row.hsync_end   = HS_EN;
        return row;
    endfunction

    function automatic pixel_t read_memory(addr_data_t addr);
        if (!mem.exists(addr)) begin
            mem[addr] = pixel_t'($urandom);
            if (mem[addr] == '0) begin
                mem[addr] = 24'h00_0001; // Zero means no pixel on the outputs
            end
        end
        return mem[addr];
    endfunction

    // Bus model, register write driver and output monitors
    always @(posedge clk) begin
        if (reset_n) begin
            now_cyc = $time / 100;
            if (vid_ctrl_i.checker_i.fail_count != 0) begin
                $display("An assertion on the DUT ports failed");
                fail_run();
            end
            if (resp_q.size() > 0 && $time == resp_q[0]) begin
                check_cmd("cmd_out", cmd_out, CMD_RESP);
                check_bits("req_out", req_out, 2'd3);
                void'(resp_q.pop_front());
            end else if (cmd_out == CMD_RESP) begin
                $display("Write response seen with no register write to answer");
                fail_run();
            end
            if (cmd_out == CMD_READ) begin
                check_bits("len_out", len_out, BURST_LEN_CODE);
                check_address("addr_data_out", addr_data_out, next_read);
                check_bits("req_out", req_out, 2'd3);
                if (beats_left != 0) begin
                    $display("Read request issued while a burst was still outstanding");
                    fail_run();
                end
                beat_addr  = addr_data_out;
                beats_left = BURST_LEN;
                next_read  = next_read + BURST_BYTES;
            end
            if (!hblank && prev_hblank) begin
                if (fall_valid) begin
                    check_count("line period", hpos_t'(now_cyc - fall_cyc),
                                period_clocks(exp_cfg.hend, exp_cfg.pdiv));
                    lines_seen++;
                end
                fall_cyc   = now_cyc;
                fall_valid = 1'b1;
                phase      = 0;
            end
            if (hblank && !prev_hblank && fall_valid) begin
                check_count("hblank low run", hpos_t'(now_cyc - fall_cyc),
                            period_clocks(exp_cfg.hsize, exp_cfg.pdiv));
            end
            if (hsync && !prev_hsync) begin
                hs_rise_cyc = now_cyc;
                hs_valid    = 1'b1;
            end
            if (!hsync && prev_hsync && hs_valid) begin
                check_count("hsync pulse", hpos_t'(now_cyc - hs_rise_cyc),
                            period_clocks(exp_cfg.hsync_end - exp_cfg.hsync_start,
                                          exp_cfg.pdiv));
            end
            if (!hblank) begin
                if (phase == 0 && {r, g, b} != '0) begin
                    if (exp_pixels.size() == 0) begin
                        $display("Pixel shown on the outputs that the bus never delivered");
                        fail_run();
                    end
                    check_pixel("rgb", {r, g, b}, exp_pixels.pop_front());
                    pixels_checked++;
                end
                phase = (phase == int'(exp_cfg.pdiv)) ? 0 : phase + 1;
            end
            prev_hblank = hblank;
            prev_hsync  = hsync;

            cmd_in       <= CMD_IDLE;
            addr_data_in <= '0;
            if (wr_phase) begin
                cmd_in       <= CMD_WRITE;
                addr_data_in <= wr_q[0].data;
                resp_q.push_back($time + 300);
                void'(wr_q.pop_front());
                wr_phase = 1'b0;
            end else if (beats_left > 0) begin
                if ($urandom % 3 != 0) begin  // Random gaps between beats
                    beat_pix = read_memory(beat_addr);
                    cmd_in       <= CMD_READ_DATA;
                    addr_data_in <= {8'h00, beat_pix};
                    exp_pixels.push_back(beat_pix);
                    beat_addr  = beat_addr + 4;
                    beats_left--;
                end
            end else if (wr_q.size() > 0) begin
                cmd_in       <= CMD_WRITE_REQ;
                addr_data_in <= wr_q[0].offset;
                wr_phase = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not complete in the allowed time");
        fail_run();
    end

    initial begin
        reset_n        = 1'b0;
        cmd_in         = CMD_IDLE;
        addr_data_in   = '0;
        void'($urandom(1));
        beats_left     = 0;
        wr_phase       = 1'b0;
        phase          = 0;
        lines_seen     = 0;
        pixels_checked = 0;
        fall_valid     = 1'b0;
        hs_valid       = 1'b0;
        prev_hblank    = 1'b1;
        prev_hsync     = 1'b0;
        next_read      = BASE;
        table_rows[0] = make_row(REG_H1, {6'd0, HSIZE, HEND});
        table_rows[1] = make_row(REG_H2, {6'd0, HS_ST, HS_EN});
        table_rows[2] = make_row(REG_BASE, BASE);
        table_rows[3] = make_row(REG_CR, {22'd0, PDIV, 4'b0000});
        table_rows[4] = make_row(REG_CR, {22'd0, PDIV, 4'b1000}); // Enable row
        exp_cfg       = table_rows[4];
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        for (int i = 0; i < 4; i++) begin
            wr_q.push_back(table_rows[i]);
        end
        wait (wr_q.size() == 0 && resp_q.size() == 0);
        @(negedge clk);
        check_idle_outputs();       // Still disabled
        wr_q.push_back(table_rows[4]);
        wait (lines_seen >= LINES);
        wait (resp_q.size() == 0);
        if (pixels_checked == 0) begin
            $display("No delivered pixel ever appeared on the outputs");
            fail_run();
        end
        if (vid_ctrl_i.checker_i.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("An assertion on the DUT ports failed");
            fail_run();
        end
    end

endmodule

`default_nettype wire

// File: verif/vid_ctrl_checker.sv
`default_nettype none

module vid_ctrl_checker (
    input logic              clk,
    input logic              reset_n,
    input logic [1:0]        req_out,
    input vid_pkg::bus_cmd_t cmd_out,
    input logic [1:0]        len_out,
    input logic              hsync,
    input logic              hblank,
    input vid_pkg::colour_t  r,
    input vid_pkg::colour_t  g,
    input vid_pkg::colour_t  b
);
    import vid_pkg::*;

    int unsigned fail_count = 0;  // Failed assertions so far

    // Sync pulse sits inside the blanking interval
    assert property (@(posedge clk) disable iff (!reset_n) hsync |-> hblank)
        else begin
            $error("hsync high outside hblank");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!reset_n) hblank |-> ({r, g, b} == '0))
        else begin
            $error("Colour outputs nonzero during hblank");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!reset_n)
        (cmd_out == CMD_READ) |-> (len_out == BURST_LEN_CODE))
        else begin
            $error("Read request with wrong burst length");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!reset_n)
        (req_out != 2'd0) |=> (req_out == 2'd0))
        else begin
            $error("req_out nonzero on two consecutive cycles");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: src/vid_ctrl.sv
`default_nettype none

module vid_ctrl #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                reset_n,
    input  vid_pkg::bus_cmd_t   cmd_in,
    input  vid_pkg::addr_data_t addr_data_in,
    output logic [1:0]          req_out,
    output vid_pkg::bus_cmd_t   cmd_out,
    output logic [1:0]          len_out,
    output vid_pkg::addr_data_t addr_data_out,
    output logic                hsync,
    output logic                hblank,
    output vid_pkg::colour_t    r,
    output vid_pkg::colour_t    g,
    output vid_pkg::colour_t    b
);
    import vid_pkg::*;

    addr_data_t                      base_address;
    logic                            wr_done;
    logic                            push;
    logic                            pop;
    logic                            empty;
    pixel_t                          pixel_in;
    pixel_t                          pixel_out;
    logic [$clog2(FIFO_DEPTH+1)-1:0] free_count;

    timing_cfg_if cfg_if ();

    vid_regs regs_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_in       (cmd_in),
        .addr_data_in (addr_data_in),
        .cfg          (cfg_if.regs),
        .base_address (base_address),
        .wr_done      (wr_done)
    );

    pixel_fetch #(.FIFO_DEPTH(FIFO_DEPTH)) fetch_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .cmd_in        (cmd_in),
        .addr_data_in  (addr_data_in),
        .en            (cfg_if.en),
        .base_address  (base_address),
        .wr_done       (wr_done),
        .free_count    (free_count),
        .req_out       (req_out),
        .len_out       (len_out),
        .cmd_out       (cmd_out),
        .addr_data_out (addr_data_out),
        .push          (push),
        .pixel_in      (pixel_in)
    );

    pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .push       (push),
        .pixel_in   (pixel_in),
        .pop        (pop),
        .pixel_out  (pixel_out),
        .empty      (empty),
        .free_count (free_count)
    );

    line_timing timing_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .cfg       (cfg_if.timing),
        .pixel_out (pixel_out),
        .empty     (empty),
        .pop       (pop),
        .hsync     (hsync),
        .hblank    (hblank),
        .r         (r),
        .g         (g),
        .b         (b)
    );

endmodule

`default_nettype wire

// File: src/line_timing.sv
`default_nettype none

module line_timing (
    input  logic              clk,
    input  logic              reset_n,
    timing_cfg_if.timing      cfg,
    input  vid_pkg::pixel_t   pixel_out,
    input  logic              empty,
    output logic              pop,
    output logic              hsync,
    output logic              hblank,
    output vid_pkg::colour_t  r,
    output vid_pkg::colour_t  g,
    output vid_pkg::colour_t  b
);
    import vid_pkg::*;

    pdiv_t div_cnt;   // Clock within the pixel period
    hpos_t hcount;    // Current pixel position
    logic  tick;      // First clock of a pixel period
    logic  last;      // Last clock of a pixel period
    logic  active;

    assign tick   = (div_cnt == '0);
    assign last   = (div_cnt == cfg.pdiv);
    assign active = (hcount < cfg.hsize);

    // Take one pixel per displayed position when one is there
    assign pop = cfg.en && tick && active && !empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            hcount  <= '0;
        end else if (!cfg.en) begin
            div_cnt <= '0;
            hcount  <= '0;
        end else begin
            div_cnt <= last ? pdiv_t'(0) : div_cnt + 1'b1;
            if (last) begin
                if (hcount == hpos_t'(cfg.hend - 1'b1)) begin
                    hcount <= '0; // End of line
                end else begin
                    hcount <= hcount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hsync  <= 1'b0;
            hblank <= 1'b1;
            r      <= '0;
            g      <= '0;
            b      <= '0;
        end else if (!cfg.en) begin
            hsync  <= 1'b0;
            hblank <= 1'b1;
            r      <= '0;
            g      <= '0;
            b      <= '0;
        end else if (tick) begin
            hblank <= !active;
            hsync  <= (hcount >= cfg.hsync_start) && (hcount < cfg.hsync_end);
            if (pop) begin
                r <= pixel_out[23:16];
                g <= pixel_out[15:8];
                b <= pixel_out[7:0];
            end else begin
                r <= '0; // Blanking or FIFO ran dry
                g <= '0;
                b <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_fifo.sv
`default_nettype none

module pixel_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            push,
    input  vid_pkg::pixel_t                 pixel_in,
    input  logic                            pop,
    output vid_pkg::pixel_t                 pixel_out,
    output logic                            empty,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] free_count
);
    import vid_pkg::*;

    localparam int AW    = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pixel_t        mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr;  // Extra bit tells full from empty
    logic [AW:0]   rd_ptr;
    logic [AW:0]   used;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;
    assign used  = wr_ptr - rd_ptr;

    assign free_count = CNT_W'(FIFO_DEPTH) - CNT_W'(used);
    assign pixel_out  = mem[rd_ptr[AW-1:0]]; // First word falls through

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= pixel_in;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_fetch.sv
`default_nettype none

module pixel_fetch #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  vid_pkg::bus_cmd_t                 cmd_in,
    input  vid_pkg::addr_data_t               addr_data_in,
    input  logic                              en,
    input  vid_pkg::addr_data_t               base_address,
    input  logic                              wr_done,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]   free_count,
    output logic [1:0]                        req_out,
    output logic [1:0]                        len_out,
    output vid_pkg::bus_cmd_t                 cmd_out,
    output vid_pkg::addr_data_t               addr_data_out,
    output logic                              push,
    output vid_pkg::pixel_t                   pixel_in
);
    import vid_pkg::*;

    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int BEAT_W = $clog2(BURST_LEN);

    fetch_state_t      state;
    addr_data_t        fetch_ptr;
    logic [BEAT_W-1:0] beat_cnt;
    logic              en_d;
    logic              beat;
    logic              last_beat;
    logic              room;
    logic              start_burst;

    assign beat      = (state == WAIT_DATA) && (cmd_in == CMD_READ_DATA);
    assign last_beat = beat && (beat_cnt == BEAT_W'(BURST_LEN - 1));

    // A push still in flight is not yet counted by the FIFO
    assign room = (free_count - CNT_W'(push)) >= CNT_W'(BURST_LEN);

    // Keep clear of a write response due next cycle and of back-to-back bids
    assign start_burst = en && room && (cmd_in != CMD_WRITE) && (req_out == 2'd0);

    always_ff @(posedge clk) begin
        if (beat) begin
            pixel_in <= addr_data_in[23:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= IDLE;
            fetch_ptr     <= '0;
            beat_cnt      <= '0;
            en_d          <= 1'b0;
            push          <= 1'b0;
            req_out       <= 2'd0;
            len_out       <= 2'd0;
            cmd_out       <= CMD_IDLE;
            addr_data_out <= '0;
        end else begin
            en_d          <= en;
            push          <= beat; // Push one cycle after the beat
            req_out       <= 2'd0;
            len_out       <= 2'd0;
            cmd_out       <= CMD_IDLE;
            addr_data_out <= '0;
            if (en && !en_d) begin
                fetch_ptr <= base_address;
            end else if (last_beat) begin
                fetch_ptr <= fetch_ptr + BURST_BYTES;
            end
            if (beat) begin
                beat_cnt <= beat_cnt + 1'b1; // Wraps after the last beat
            end
            case (state)
                IDLE: begin
                    if (wr_done) begin
                        req_out <= 2'd3;
                        cmd_out <= CMD_RESP;
                        state   <= RESPOND;
                    end else if (start_burst) begin
                        req_out       <= 2'd3;
                        cmd_out       <= CMD_READ;
                        len_out       <= BURST_LEN_CODE;
                        addr_data_out <= fetch_ptr;
                        state         <= WAIT_DATA;
                    end
                end
                RESPOND: state <= IDLE;
                WAIT_DATA: begin
                    if (wr_done) begin // Response may overlap returning beats
                        req_out <= 2'd3;
                        cmd_out <= CMD_RESP;
                    end
                    if (last_beat) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/vid_regs.sv
`default_nettype none

module vid_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  vid_pkg::bus_cmd_t   cmd_in,
    input  vid_pkg::addr_data_t addr_data_in,
    timing_cfg_if.regs          cfg,
    output vid_pkg::addr_data_t base_address,
    output logic                wr_done
);
    import vid_pkg::*;

    localparam int CR_EN_BIT = 3;

    addr_data_t wr_offset;  // Offset from the request phase
    logic       wr_pending; // Request seen, data phase expected next
    logic       wr_data;

    assign wr_data = wr_pending && (cmd_in == CMD_WRITE);

    always_ff @(posedge clk) begin
        if (cmd_in == CMD_WRITE_REQ) begin
            wr_offset <= addr_data_in;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_pending      <= 1'b0;
            wr_done         <= 1'b0;
            cfg.en          <= 1'b0;
            cfg.pdiv        <= '0;
            cfg.hend        <= '0;
            cfg.hsize       <= '0;
            cfg.hsync_start <= '0;
            cfg.hsync_end   <= '0;
            base_address    <= '0;
        end else begin
            wr_pending <= (cmd_in == CMD_WRITE_REQ);
            wr_done    <= wr_data; // Unknown offsets still get a response
            if (wr_data) begin
                case (wr_offset)
                    REG_CR: begin
                        cfg.en   <= addr_data_in[CR_EN_BIT];
                        cfg.pdiv <= addr_data_in[9:4];
                    end
                    REG_H1: begin
                        cfg.hend  <= addr_data_in[12:0];
                        cfg.hsize <= addr_data_in[25:13];
                    end
                    REG_H2: begin
                        cfg.hsync_end   <= addr_data_in[12:0];
                        cfg.hsync_start <= addr_data_in[25:13];
                    end
                    REG_BASE: base_address <= addr_data_in;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: src/timing_cfg_if.sv
`default_nettype none

interface timing_cfg_if;
    import vid_pkg::*;

    logic  en;           // Controller enable
    pdiv_t pdiv;         // Clocks per pixel minus one
    hpos_t hend;         // Total pixels per line
    hpos_t hsize;        // Displayed pixels per line
    hpos_t hsync_start;
    hpos_t hsync_end;

    modport regs   (output en, pdiv, hend, hsize, hsync_start, hsync_end);
    modport timing (input  en, pdiv, hend, hsize, hsync_start, hsync_end);

endinterface

`default_nettype wire

// File: src/vid_pkg.sv
`default_nettype none

package vid_pkg;

    typedef logic [31:0] addr_data_t;  // Bus address or data word
    typedef logic [23:0] pixel_t;      // R in [23:16], G in [15:8], B in [7:0]
    typedef logic [7:0]  colour_t;
    typedef logic [12:0] hpos_t;       // Horizontal position or length
    typedef logic [5:0]  pdiv_t;       // Pixel divider

    typedef enum logic [2:0] {
        CMD_IDLE      = 3'd0,
        CMD_WRITE     = 3'd1,  // Write data phase
        CMD_READ      = 3'd2,  // Read request
        CMD_READ_DATA = 3'd3,  // Read data phase
        CMD_WRITE_REQ = 3'd4,  // Write request with address
        CMD_RESP      = 3'd5   // Write response
    } bus_cmd_t;

    localparam addr_data_t REG_CR   = 32'h0000_0000;
    localparam addr_data_t REG_H1   = 32'h0000_0028;
    localparam addr_data_t REG_H2   = 32'h0000_0030;
    localparam addr_data_t REG_BASE = 32'h0000_0048;

    localparam int unsigned BURST_LEN      = 4;      // Beats per read
    localparam logic [1:0]  BURST_LEN_CODE = 2'd2;   // len_out code for 4 beats
    localparam addr_data_t  BURST_BYTES    = 32'd16; // Pointer step per burst

    typedef enum logic [1:0] {
        IDLE,
        RESPOND,
        WAIT_DATA
    } fetch_state_t;

endpackage

`default_nettype wire
